/* build.f */
+incdir+common
common/csr_pkg.sv
common/pwr_pkg.sv
common/csr_bus_if.sv
hw/csr/csr_access_ctrl.sv
hw/csr/csr_machine_regs.sv
hw/pmu/perf_counters.sv
hw/wfi_fsm.sv
hw/csr_unit_top.sv
tb/tb_csr_unit.sv

/* common/csr_bus_if.sv */
`timescale 1ns/10ps

interface csr_bus_if
    import csr_pkg::*;
();

    // Shared write port and address
    logic      wr_en;
    csr_addr_t addr;
    xlen_t     wdata;

    // Per-owner decode result and read data
    logic      regs_hit;
    xlen_t     regs_rdata;
    logic      pmu_hit;
    xlen_t     pmu_rdata;

    modport ctrl (
        output wr_en, addr, wdata,
        input  regs_hit, regs_rdata, pmu_hit, pmu_rdata
    );

    modport regs (input wr_en, addr, wdata, output regs_hit, regs_rdata);

    modport pmu (input wr_en, addr, wdata, output pmu_hit, pmu_rdata);

endinterface

/* common/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data word width
`define CSR_XLEN 32

// Machine status and interrupt CSRs
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MIP       12'h344

// Counters, low and high halves
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82

// Bit positions in mie and mip
`define IRQ_BIT_MSI 3
`define IRQ_BIT_MTI 7
`define IRQ_BIT_MEI 11

// Global enable in mstatus
`define MSTATUS_BIT_MIE 3

`endif

/* common/csr_pkg.sv */
`include "csr_consts.svh"

package csr_pkg;

    // One CSR data word
    typedef logic [`CSR_XLEN-1:0] xlen_t;

    // CSR address space is 12 bits wide
    typedef logic [11:0] csr_addr_t;

    // Access operation carried with each request
    typedef enum logic [1:0] {
        CSR_READ  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

endpackage

/* common/pwr_pkg.sv */
package pwr_pkg;

    // Interrupt cause, equal to the mip bit position
    typedef logic [3:0] irq_cause_t;

    // Sleep control states
    typedef enum logic [1:0] {
        WFI_RUN   = 2'd0,
        WFI_SLEEP = 2'd1,
        WFI_WAKE  = 2'd2
    } wfi_state_e;

endpackage

/* hw/csr/csr_access_ctrl.sv */
`timescale 1ns/10ps

module csr_access_ctrl
    import csr_pkg::*;
(
    input  logic      clk_wfi,
    input  logic      rstn_sync,
    input  logic      csr_req_valid_i,
    output logic      csr_req_ready_o,
    input  csr_op_e   csr_op_i,
    input  csr_addr_t csr_addr_i,
    input  xlen_t     csr_wdata_i,
    output logic      csr_rsp_valid_o,
    output xlen_t     csr_rsp_rdata_o,
    output logic      csr_rsp_err_o,
    input  logic      run_i,
    csr_bus_if.ctrl   bus
);

logic  accept;
logic  hit;
xlen_t old_val;
xlen_t new_val;

// No request is taken while asleep
assign csr_req_ready_o = run_i;
assign accept          = csr_req_valid_i & run_i;

// Owners decode the address themselves
assign bus.addr = csr_addr_i;
assign hit      = bus.regs_hit | bus.pmu_hit;

always_comb begin
    if (bus.regs_hit) begin
        old_val = bus.regs_rdata;
    end else if (bus.pmu_hit) begin
        old_val = bus.pmu_rdata;
    end else begin
        old_val = '0;
    end
end

// Read-modify-write value
always_comb begin
    case (csr_op_i)
        CSR_WRITE: new_val = csr_wdata_i;
        CSR_SET:   new_val = old_val | csr_wdata_i;
        CSR_CLEAR: new_val = old_val & ~csr_wdata_i;
        default:   new_val = old_val;
    endcase
end

assign bus.wdata = new_val;
assign bus.wr_en = accept & hit & (csr_op_i != CSR_READ);

always_ff @(posedge clk_wfi or negedge rstn_sync) begin
    if (~rstn_sync) begin
        csr_rsp_valid_o <= 1'b0;
    end else begin
        csr_rsp_valid_o <= accept;
    end
end

// Old value and error flag of the accepted request
always_ff @(posedge clk_wfi or negedge rstn_sync) begin
    if (~rstn_sync) begin
        csr_rsp_rdata_o <= '0;
        csr_rsp_err_o   <= 1'b0;
    end else if (accept) begin
        csr_rsp_rdata_o <= old_val;
        csr_rsp_err_o   <= ~hit;
    end
end

endmodule

/* hw/csr/csr_machine_regs.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_machine_regs
    import csr_pkg::*;
    import pwr_pkg::*;
(
    input  logic       clk_wfi,
    input  logic       rstn_sync,
    input  logic       msip_i,
    input  logic       mtip_i,
    input  logic       meip_i,
    output logic       wake_o,
    output logic       irq_o,
    output irq_cause_t irq_cause_o,
    csr_bus_if.regs    bus
);

localparam xlen_t MIE_MASK = xlen_t'((1 << `IRQ_BIT_MSI) | (1 << `IRQ_BIT_MTI) |
                                     (1 << `IRQ_BIT_MEI));

logic  mstatus_mie;
xlen_t mie_q;
xlen_t mip_q;
xlen_t mscratch_q;
xlen_t mstatus_rd;
xlen_t mip_in;
xlen_t irq_active;

always_comb begin
    mstatus_rd                   = '0;
    mstatus_rd[`MSTATUS_BIT_MIE] = mstatus_mie;
    mip_in                       = '0;
    mip_in[`IRQ_BIT_MSI]         = msip_i;
    mip_in[`IRQ_BIT_MTI]         = mtip_i;
    mip_in[`IRQ_BIT_MEI]         = meip_i;
end

always_comb begin
    bus.regs_hit   = 1'b1;
    bus.regs_rdata = '0;
    case (bus.addr)
        `CSR_ADDR_MSTATUS:  bus.regs_rdata = mstatus_rd;
        `CSR_ADDR_MIE:      bus.regs_rdata = mie_q;
        `CSR_ADDR_MSCRATCH: bus.regs_rdata = mscratch_q;
        `CSR_ADDR_MIP:      bus.regs_rdata = mip_q;
        default:            bus.regs_hit   = 1'b0;
    endcase
end

// mip is sampled every cycle, so writes to it fall through
always_ff @(posedge clk_wfi or negedge rstn_sync) begin
    if (~rstn_sync) begin
        mstatus_mie <= 1'b0;
        mie_q       <= '0;
        mscratch_q  <= '0;
        mip_q       <= '0;
    end else begin
        mip_q <= mip_in;
        if (bus.wr_en) begin
            case (bus.addr)
                `CSR_ADDR_MSTATUS:  mstatus_mie <= bus.wdata[`MSTATUS_BIT_MIE];
                `CSR_ADDR_MIE:      mie_q       <= bus.wdata & MIE_MASK;
                `CSR_ADDR_MSCRATCH: mscratch_q  <= bus.wdata;
                default:            ;
            endcase
        end
    end
end

// Wake ignores the global enable
assign irq_active = mip_q & mie_q;
assign wake_o     = |irq_active;
assign irq_o      = mstatus_mie & wake_o;

// External first, then software, then timer
always_comb begin
    if (irq_active[`IRQ_BIT_MEI]) begin
        irq_cause_o = irq_cause_t'(`IRQ_BIT_MEI);
    end else if (irq_active[`IRQ_BIT_MSI]) begin
        irq_cause_o = irq_cause_t'(`IRQ_BIT_MSI);
    end else if (irq_active[`IRQ_BIT_MTI]) begin
        irq_cause_o = irq_cause_t'(`IRQ_BIT_MTI);
    end else begin
        irq_cause_o = '0;
    end
end

endmodule

/* hw/csr_unit_top.sv */
`timescale 1ns/10ps

module csr_unit_top
    import csr_pkg::*;
    import pwr_pkg::*;
(
    input  logic       clk_wfi,
    input  logic       rstn_sync,
    input  logic       csr_req_valid_i,
    output logic       csr_req_ready_o,
    input  csr_op_e    csr_op_i,
    input  csr_addr_t  csr_addr_i,
    input  xlen_t      csr_wdata_i,
    output logic       csr_rsp_valid_o,
    output xlen_t      csr_rsp_rdata_o,
    output logic       csr_rsp_err_o,
    input  logic       retire_i,
    input  logic       wfi_i,
    input  logic       msip_i,
    input  logic       mtip_i,
    input  logic       meip_i,
    output logic       sleep_o,
    output logic       irq_o,
    output irq_cause_t irq_cause_o
);

logic run;
logic wake;

csr_bus_if u_bus ();

csr_access_ctrl u_ctrl (
    .clk_wfi         ( clk_wfi         ),
    .rstn_sync       ( rstn_sync       ),
    .csr_req_valid_i ( csr_req_valid_i ),
    .csr_req_ready_o ( csr_req_ready_o ),
    .csr_op_i        ( csr_op_i        ),
    .csr_addr_i      ( csr_addr_i      ),
    .csr_wdata_i     ( csr_wdata_i     ),
    .csr_rsp_valid_o ( csr_rsp_valid_o ),
    .csr_rsp_rdata_o ( csr_rsp_rdata_o ),
    .csr_rsp_err_o   ( csr_rsp_err_o   ),
    .run_i           ( run             ),
    .bus             ( u_bus.ctrl      )
);

csr_machine_regs u_regs (
    .clk_wfi     ( clk_wfi     ),
    .rstn_sync   ( rstn_sync   ),
    .msip_i      ( msip_i      ),
    .mtip_i      ( mtip_i      ),
    .meip_i      ( meip_i      ),
    .wake_o      ( wake        ),
    .irq_o       ( irq_o       ),
    .irq_cause_o ( irq_cause_o ),
    .bus         ( u_bus.regs  )
);

perf_counters u_pmu (
    .clk_wfi   ( clk_wfi   ),
    .rstn_sync ( rstn_sync ),
    .run_i     ( run       ),
    .retire_i  ( retire_i  ),
    .bus       ( u_bus.pmu )
);

wfi_fsm u_wfi (
    .clk_wfi   ( clk_wfi   ),
    .rstn_sync ( rstn_sync ),
    .wfi_i     ( wfi_i     ),
    .wake_i    ( wake      ),
    .run_o     ( run       ),
    .sleep_o   ( sleep_o   )
);

endmodule

/* hw/pmu/perf_counters.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module perf_counters
    import csr_pkg::*;
(
    input  logic   clk_wfi,
    input  logic   rstn_sync,
    input  logic   run_i,
    input  logic   retire_i,
    csr_bus_if.pmu bus
);

logic [2*`CSR_XLEN-1:0] mcycle_q;
logic [2*`CSR_XLEN-1:0] minstret_q;

// A write to either half wins over the increment
function automatic logic [2*`CSR_XLEN-1:0] next_count(
    input logic [2*`CSR_XLEN-1:0] cnt,
    input logic                   lo_wr,
    input logic                   hi_wr,
    input xlen_t                  wdata,
    input logic                   inc
);
    logic [2*`CSR_XLEN-1:0] nxt;
    nxt = cnt;
    if (lo_wr) begin
        nxt[`CSR_XLEN-1:0] = wdata;
    end else if (hi_wr) begin
        nxt[2*`CSR_XLEN-1:`CSR_XLEN] = wdata;
    end else if (inc) begin
        nxt = cnt + 1'b1;
    end
    return nxt;
endfunction

always_comb begin
    bus.pmu_hit   = 1'b1;
    bus.pmu_rdata = '0;
    case (bus.addr)
        `CSR_ADDR_MCYCLE:    bus.pmu_rdata = mcycle_q[`CSR_XLEN-1:0];
        `CSR_ADDR_MCYCLEH:   bus.pmu_rdata = mcycle_q[2*`CSR_XLEN-1:`CSR_XLEN];
        `CSR_ADDR_MINSTRET:  bus.pmu_rdata = minstret_q[`CSR_XLEN-1:0];
        `CSR_ADDR_MINSTRETH: bus.pmu_rdata = minstret_q[2*`CSR_XLEN-1:`CSR_XLEN];
        default:             bus.pmu_hit   = 1'b0;
    endcase
end

always_ff @(posedge clk_wfi or negedge rstn_sync) begin
    if (~rstn_sync) begin
        mcycle_q   <= '0;
        minstret_q <= '0;
    end else begin
        mcycle_q   <= next_count(mcycle_q,
                                 bus.wr_en && bus.addr == `CSR_ADDR_MCYCLE,
                                 bus.wr_en && bus.addr == `CSR_ADDR_MCYCLEH,
                                 bus.wdata, run_i);
        minstret_q <= next_count(minstret_q,
                                 bus.wr_en && bus.addr == `CSR_ADDR_MINSTRET,
                                 bus.wr_en && bus.addr == `CSR_ADDR_MINSTRETH,
                                 bus.wdata, retire_i);
    end
end

endmodule

/* hw/wfi_fsm.sv */
`timescale 1ns/10ps

module wfi_fsm
    import pwr_pkg::*;
(
    input  logic clk_wfi,
    input  logic rstn_sync,
    input  logic wfi_i,
    input  logic wake_i,
    output logic run_o,
    output logic sleep_o
);

wfi_state_e state_q;
wfi_state_e state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        WFI_RUN: begin
            if (wfi_i) begin
                state_d = WFI_SLEEP;
            end
        end
        WFI_SLEEP: begin
            // Any enabled pending line, global enable or not
            if (wake_i) begin
                state_d = WFI_WAKE;
            end
        end
        WFI_WAKE: begin
            state_d = WFI_RUN;
        end
        default: begin
            state_d = WFI_RUN;
        end
    endcase
end

always_ff @(posedge clk_wfi or negedge rstn_sync) begin
    if (~rstn_sync) begin
        state_q <= WFI_RUN;
    end else begin
        state_q <= state_d;
    end
end

// Stands in for the gated clock
assign run_o   = (state_q == WFI_RUN);
assign sleep_o = (state_q == WFI_SLEEP) | (state_q == WFI_WAKE);

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_csr_unit -f build.f -o tb_csr_unit
./obj_dir/tb_csr_unit > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* tb/tb_csr_unit.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module tb_csr_unit
    import csr_pkg::*;
    import pwr_pkg::*;
();

localparam int        SH_MSCRATCH   = 0;
localparam int        SH_MIE        = 1;
localparam int        SH_MSTATUS    = 2;
localparam int        RETIRE_PULSES = 7;
localparam csr_addr_t ADDR_UNMAPPED = 12'h7C0;
localparam xlen_t     MIE_BITS      = xlen_t'((1 << `IRQ_BIT_MSI) | (1 << `IRQ_BIT_MTI) |
                                              (1 << `IRQ_BIT_MEI));
localparam xlen_t     MSTATUS_BITS  = xlen_t'(1 << `MSTATUS_BIT_MIE);

logic       clk_wfi;
logic       rstn_sync;
logic       csr_req_valid_i;
logic       csr_req_ready_o;
csr_op_e    csr_op_i;
csr_addr_t  csr_addr_i;
xlen_t      csr_wdata_i;
logic       csr_rsp_valid_o;
xlen_t      csr_rsp_rdata_o;
logic       csr_rsp_err_o;
logic       retire_i;
logic       wfi_i;
logic       msip_i;
logic       mtip_i;
logic       meip_i;
logic       sleep_o;
logic       irq_o;
irq_cause_t irq_cause_o;

int unsigned lcg_state;
int          error_count;
int          check_count;
int          test_count;
int          test_errors;
int          req_count;
int          edge_cnt;
int          accept_edge;
xlen_t       shadow [3];

csr_unit_top DUT (.*);

always #4 clk_wfi = ~clk_wfi;

always @(posedge clk_wfi) begin
    edge_cnt <= edge_cnt + 1;
end

// Budget grows with every request issued
always @(posedge clk_wfi) begin
    if (edge_cnt > 40 * req_count + 200) begin
        $display("Timeout: the run did not finish within %0d cycles", edge_cnt);
        $display("Errors found");
        $finish;
    end
end

function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return xlen_t'(lcg_state);
endfunction

// New register value for one access
function automatic xlen_t rmw_ref(input csr_op_e op, input xlen_t old_val, input xlen_t data);
    case (op)
        CSR_WRITE: return data;
        CSR_SET:   return old_val | data;
        CSR_CLEAR: return old_val ^ (old_val & data);
        default:   return old_val;
    endcase
endfunction

// Priority is external, software, timer
function automatic irq_cause_t cause_ref(input xlen_t active);
    if (active[`IRQ_BIT_MEI]) begin
        return irq_cause_t'(`IRQ_BIT_MEI);
    end
    if (active[`IRQ_BIT_MSI]) begin
        return irq_cause_t'(`IRQ_BIT_MSI);
    end
    if (active[`IRQ_BIT_MTI]) begin
        return irq_cause_t'(`IRQ_BIT_MTI);
    end
    return '0;
endfunction

task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
endtask

task automatic check_cause(input string name, input irq_cause_t exp, input irq_cause_t act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic begin_test();
    test_errors = error_count;
endtask

task automatic end_test(input string name);
    test_count++;
    if (error_count == test_errors) begin
        $display("test %-14s ok", name);
    end else begin
        $display("test %-14s %0d mismatches", name, error_count - test_errors);
    end
endtask

task automatic issue_request(input csr_op_e op, input csr_addr_t addr, input xlen_t data);
    @(negedge clk_wfi);
    csr_req_valid_i = 1'b1;
    csr_op_i        = op;
    csr_addr_i      = addr;
    csr_wdata_i     = data;
    req_count++;
endtask

// Request stays held until ready
task automatic collect_response(output xlen_t rdata, output logic err);
    while (csr_req_ready_o !== 1'b1) begin
        @(negedge clk_wfi);
    end
    @(negedge clk_wfi);
    csr_req_valid_i = 1'b0;
    accept_edge     = edge_cnt;
    check_count++;
    if (csr_rsp_valid_o !== 1'b1) begin
        error_count++;
        $display("No response in the cycle after the request to 0x%03h", csr_addr_i);
    end
    rdata = csr_rsp_rdata_o;
    err   = csr_rsp_err_o;
endtask

task automatic csr_access(input csr_op_e op, input csr_addr_t addr, input xlen_t data,
                          output xlen_t rdata, output logic err);
    issue_request(op, addr, data);
    collect_response(rdata, err);
endtask

// Write, then a read of the same CSR accepted in the very next cycle
task automatic write_then_read(input csr_addr_t addr, input xlen_t data,
                               output xlen_t old_val, output logic wr_err,
                               output xlen_t rdata);
    logic rd_err;
    issue_request(CSR_WRITE, addr, data);
    while (csr_req_ready_o !== 1'b1) begin
        @(negedge clk_wfi);
    end
    @(negedge clk_wfi);
    check_bit("write_rsp_valid", 1'b1, csr_rsp_valid_o);
    old_val  = csr_rsp_rdata_o;
    wr_err   = csr_rsp_err_o;
    csr_op_i = CSR_READ;
    req_count++;
    collect_response(rdata, rd_err);
endtask

task automatic rmw_on_mscratch();
    xlen_t   data;
    xlen_t   rd;
    logic    err;
    csr_op_e op;
    begin_test();
    for (int i = 0; i < 30; i++) begin
        data = lcg_next();
        op   = csr_op_e'(data[17:16]);
        data = lcg_next();
        csr_access(op, `CSR_ADDR_MSCRATCH, data, rd, err);
        check_data("mscratch_rmw", shadow[SH_MSCRATCH], rd);
        shadow[SH_MSCRATCH] = rmw_ref(op, shadow[SH_MSCRATCH], data);
    end
    end_test("mscratch_rmw");
endtask

task automatic masking_and_errors();
    xlen_t rd;
    xlen_t back;
    logic  err;
    begin_test();
    csr_access(CSR_WRITE, ADDR_UNMAPPED, lcg_next(), rd, err);
    check_bit("unmapped_err", 1'b1, err);
    check_data("unmapped_rdata", '0, rd);
    write_then_read(`CSR_ADDR_MIP, '1, rd, err, back);
    check_bit("mip_write_err", 1'b0, err);
    check_data("mip_read_only", '0, back);
    write_then_read(`CSR_ADDR_MIE, '1, rd, err, back);
    check_data("mie_old", shadow[SH_MIE], rd);
    shadow[SH_MIE] = rmw_ref(CSR_WRITE, shadow[SH_MIE], '1) & MIE_BITS;
    check_data("mie_mask", shadow[SH_MIE], back);
    write_then_read(`CSR_ADDR_MSTATUS, '1, rd, err, back);
    check_data("mstatus_old", shadow[SH_MSTATUS], rd);
    shadow[SH_MSTATUS] = rmw_ref(CSR_WRITE, shadow[SH_MSTATUS], '1) & MSTATUS_BITS;
    check_data("mstatus_mask", shadow[SH_MSTATUS], back);
    end_test("masking");
endtask

task automatic counter_writes();
    xlen_t       lo;
    xlen_t       hi;
    xlen_t       rd;
    xlen_t       first;
    logic        err;
    logic [63:0] expected;
    begin_test();
    lo = lcg_next();
    hi = lcg_next();
    csr_access(CSR_WRITE, `CSR_ADDR_MINSTRET, lo, rd, err);
    csr_access(CSR_WRITE, `CSR_ADDR_MINSTRETH, hi, rd, err);
    for (int i = 0; i < RETIRE_PULSES; i++) begin
        @(negedge clk_wfi);
        retire_i = 1'b1;
        @(negedge clk_wfi);
        retire_i = 1'b0;
    end
    expected = {hi, lo} + 64'(RETIRE_PULSES);
    csr_access(CSR_READ, `CSR_ADDR_MINSTRET, '0, rd, err);
    check_data("minstret_lo", expected[31:0], rd);
    csr_access(CSR_READ, `CSR_ADDR_MINSTRETH, '0, rd, err);
    check_data("minstret_hi", expected[63:32], rd);
    csr_access(CSR_READ, `CSR_ADDR_MCYCLE, '0, first, err);
    csr_access(CSR_READ, `CSR_ADDR_MCYCLE, '0, rd, err);
    check_bit("mcycle_advances", 1'b1, rd > first);
    end_test("counters");
endtask

task automatic irq_priority();
    xlen_t      r;
    xlen_t      rd;
    xlen_t      mie_val;
    xlen_t      status;
    xlen_t      pend;
    logic       err;
    logic [2:0] lines;
    irq_cause_t exp_cause;
    begin_test();
    for (int i = 0; i < 16; i++) begin
        r       = lcg_next();
        lines   = r[20:18];
        mie_val = (r >> 12) & MIE_BITS;
        status  = '0;
        status[`MSTATUS_BIT_MIE] = r[22];
        // All three lines, then software against timer
        if (i < 2) begin
            lines   = (i == 0) ? 3'b111 : 3'b011;
            mie_val = MIE_BITS;
            status  = MSTATUS_BITS;
        end
        csr_access(CSR_WRITE, `CSR_ADDR_MIE, mie_val, rd, err);
        shadow[SH_MIE] = mie_val;
        csr_access(CSR_WRITE, `CSR_ADDR_MSTATUS, status, rd, err);
        shadow[SH_MSTATUS] = status;
        @(negedge clk_wfi);
        {meip_i, mtip_i, msip_i} = lines;
        @(negedge clk_wfi);
        pend                 = '0;
        pend[`IRQ_BIT_MSI]   = lines[0];
        pend[`IRQ_BIT_MTI]   = lines[1];
        pend[`IRQ_BIT_MEI]   = lines[2];
        exp_cause            = cause_ref(pend & mie_val);
        check_cause("irq_cause", exp_cause, irq_cause_o);
        check_bit("irq_request", status[`MSTATUS_BIT_MIE] & (|(pend & mie_val)), irq_o);
    end
    @(negedge clk_wfi);
    {meip_i, mtip_i, msip_i} = 3'b000;
    end_test("irq_priority");
endtask

task automatic sleep_and_wake();
    xlen_t rd;
    xlen_t c0;
    xlen_t c1;
    xlen_t data;
    logic  err;
    int    pa;
    int    ew;
    int    e1;
    begin_test();
    // Global enable off, wake still follows mie
    csr_access(CSR_WRITE, `CSR_ADDR_MSTATUS, '0, rd, err);
    shadow[SH_MSTATUS] = '0;
    data = '0;
    data[`IRQ_BIT_MEI] = 1'b1;
    csr_access(CSR_WRITE, `CSR_ADDR_MIE, data, rd, err);
    shadow[SH_MIE] = data;
    csr_access(CSR_READ, `CSR_ADDR_MCYCLE, '0, c0, err);
    pa = accept_edge;
    @(negedge clk_wfi);
    wfi_i = 1'b1;
    @(negedge clk_wfi);
    wfi_i = 1'b0;
    ew = edge_cnt;
    check_bit("sleep_entered", 1'b1, sleep_o);
    issue_request(CSR_READ, `CSR_ADDR_MSCRATCH, '0);
    for (int i = 0; i < 4; i++) begin
        @(negedge clk_wfi);
        check_bit("ready_asleep", 1'b0, csr_req_ready_o);
        check_bit("rsp_asleep", 1'b0, csr_rsp_valid_o);
    end
    meip_i = 1'b1;
    e1 = edge_cnt + 1;
    @(negedge clk_wfi);
    check_bit("sleep_edge_1", 1'b1, sleep_o);
    @(negedge clk_wfi);
    check_bit("sleep_edge_2", 1'b1, sleep_o);
    @(negedge clk_wfi);
    check_bit("sleep_edge_3", 1'b0, sleep_o);
    collect_response(rd, err);
    check_data("held_request", shadow[SH_MSCRATCH], rd);
    csr_access(CSR_READ, `CSR_ADDR_MCYCLE, '0, c1, err);
    // Edges from the one after the WFI edge up to the RUN return are frozen
    check_data("mcycle_frozen", c0 + xlen_t'((accept_edge - pa) - (e1 + 2 - ew)), c1);
    @(negedge clk_wfi);
    meip_i = 1'b0;
    end_test("sleep_wake");
endtask

initial begin
    clk_wfi         = 1'b0;
    rstn_sync       = 1'b0;
    csr_req_valid_i = 1'b0;
    csr_op_i        = CSR_READ;
    csr_addr_i      = '0;
    csr_wdata_i     = '0;
    retire_i        = 1'b0;
    wfi_i           = 1'b0;
    msip_i          = 1'b0;
    mtip_i          = 1'b0;
    meip_i          = 1'b0;
    lcg_state       = 56442;
    error_count     = 0;
    check_count     = 0;
    test_count      = 0;
    req_count       = 0;
    edge_cnt        = 0;
    accept_edge     = 0;
    shadow          = '{default: '0};
    repeat (8) @(posedge clk_wfi);
    @(negedge clk_wfi);
    rstn_sync = 1'b1;
    @(negedge clk_wfi);
    begin_test();
    check_bit("reset_ready", 1'b1, csr_req_ready_o);
    check_bit("reset_rsp_valid", 1'b0, csr_rsp_valid_o);
    check_bit("reset_sleep", 1'b0, sleep_o);
    check_bit("reset_irq", 1'b0, irq_o);
    end_test("reset");
    rmw_on_mscratch();
    masking_and_errors();
    counter_writes();
    irq_priority();
    sleep_and_wake();
    $display("Summary: %0d tests, %0d checks, %0d mismatches", test_count, check_count,
             error_count);
    if (error_count == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

endmodule
